// ==== include/rv_opcodes.svh ====
/* RV32I opcode, funct3 and funct7 encodings for the instructions that decode accepts.
   Included into the decode package; holds constants only */
`ifndef RV_OPCODES_SVH
`define RV_OPCODES_SVH

// Major opcodes, instr[6:0]
localparam logic [6:0] OPC_OP       = 7'b0110011;
localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
localparam logic [6:0] OPC_LUI      = 7'b0110111;
localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
localparam logic [6:0] OPC_LOAD     = 7'b0000011;
localparam logic [6:0] OPC_STORE    = 7'b0100011;
localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
localparam logic [6:0] OPC_JAL      = 7'b1101111;
localparam logic [6:0] OPC_JALR     = 7'b1100111;
localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

// ALU funct3, shared by OP and OP-IMM
localparam logic [2:0] F3_ADD  = 3'b000;
localparam logic [2:0] F3_SLL  = 3'b001;
localparam logic [2:0] F3_SLT  = 3'b010;
localparam logic [2:0] F3_SLTU = 3'b011;
localparam logic [2:0] F3_XOR  = 3'b100;
localparam logic [2:0] F3_SR   = 3'b101;
localparam logic [2:0] F3_OR   = 3'b110;
localparam logic [2:0] F3_AND  = 3'b111;

// Branch compare funct3
localparam logic [2:0] F3_BEQ  = 3'b000;
localparam logic [2:0] F3_BNE  = 3'b001;
localparam logic [2:0] F3_BLT  = 3'b100;
localparam logic [2:0] F3_BGE  = 3'b101;
localparam logic [2:0] F3_BLTU = 3'b110;
localparam logic [2:0] F3_BGEU = 3'b111;

// Access size for loads and stores
localparam logic [2:0] F3_B  = 3'b000;
localparam logic [2:0] F3_H  = 3'b001;
localparam logic [2:0] F3_W  = 3'b010;
localparam logic [2:0] F3_BU = 3'b100;
localparam logic [2:0] F3_HU = 3'b101;

localparam logic [2:0] F3_JALR  = 3'b000;
localparam logic [2:0] F3_FENCE = 3'b000;
localparam logic [2:0] F3_PRIV  = 3'b000;

// funct7, where ALT selects SUB and SRA
localparam logic [6:0] F7_BASE = 7'b0000000;
localparam logic [6:0] F7_ALT  = 7'b0100000;

// The rs2 field tells ECALL from EBREAK
localparam logic [4:0] PRIV_ECALL  = 5'd0;
localparam logic [4:0] PRIV_EBREAK = 5'd1;

`endif

// ==== hw/rv_decode_pkg.sv ====
/* Shared widths, operation codes and the instruction word type for the decode stage.
   Modules pull it in with a wildcard import in their headers */
package rv_decode_pkg;

	localparam int W_ADDR    = 32;
	localparam int W_DATA    = 32;
	localparam int W_REGADDR = 5;
	localparam int W_ALUOP   = 4;
	localparam int W_MEMOP   = 4;
	localparam int W_BCOND   = 2;
	localparam int W_EXCEPT  = 3;
	localparam int W_IMMSEL  = 3;

	`include "rv_opcodes.svh"

	// ------------------------------------------------------------
	// Execute control encodings

	localparam logic [W_ALUOP-1:0] ALUOP_ADD = 4'd0;
	localparam logic [W_ALUOP-1:0] ALUOP_SUB = 4'd1;
	localparam logic [W_ALUOP-1:0] ALUOP_LT  = 4'd2;
	localparam logic [W_ALUOP-1:0] ALUOP_LTU = 4'd3;
	localparam logic [W_ALUOP-1:0] ALUOP_XOR = 4'd4;
	localparam logic [W_ALUOP-1:0] ALUOP_OR  = 4'd5;
	localparam logic [W_ALUOP-1:0] ALUOP_AND = 4'd6;
	localparam logic [W_ALUOP-1:0] ALUOP_SLL = 4'd7;
	localparam logic [W_ALUOP-1:0] ALUOP_SRL = 4'd8;
	localparam logic [W_ALUOP-1:0] ALUOP_SRA = 4'd9;

	localparam logic [W_MEMOP-1:0] MEMOP_NONE = 4'd0;
	localparam logic [W_MEMOP-1:0] MEMOP_LB   = 4'd1;
	localparam logic [W_MEMOP-1:0] MEMOP_LH   = 4'd2;
	localparam logic [W_MEMOP-1:0] MEMOP_LW   = 4'd3;
	localparam logic [W_MEMOP-1:0] MEMOP_LBU  = 4'd4;
	localparam logic [W_MEMOP-1:0] MEMOP_LHU  = 4'd5;
	localparam logic [W_MEMOP-1:0] MEMOP_SB   = 4'd6;
	localparam logic [W_MEMOP-1:0] MEMOP_SH   = 4'd7;
	localparam logic [W_MEMOP-1:0] MEMOP_SW   = 4'd8;

	localparam logic [W_BCOND-1:0] BCOND_NEVER  = 2'd0;
	localparam logic [W_BCOND-1:0] BCOND_ALWAYS = 2'd1;
	localparam logic [W_BCOND-1:0] BCOND_ZERO   = 2'd2;
	localparam logic [W_BCOND-1:0] BCOND_NZERO  = 2'd3;

	localparam logic [W_EXCEPT-1:0] EXCEPT_NONE          = 3'd0;
	localparam logic [W_EXCEPT-1:0] EXCEPT_ECALL         = 3'd1;
	localparam logic [W_EXCEPT-1:0] EXCEPT_EBREAK        = 3'd2;
	localparam logic [W_EXCEPT-1:0] EXCEPT_INSTR_ILLEGAL = 3'd3;
	localparam logic [W_EXCEPT-1:0] EXCEPT_INSTR_FAULT   = 3'd4;

	localparam logic ALUSRCA_RS1 = 1'b0;
	localparam logic ALUSRCA_PC  = 1'b1;
	localparam logic ALUSRCB_RS2 = 1'b0;
	localparam logic ALUSRCB_IMM = 1'b1;

	// LINK is the return-address offset, a constant 4
	localparam logic [W_IMMSEL-1:0] IMMSEL_I    = 3'd0;
	localparam logic [W_IMMSEL-1:0] IMMSEL_S    = 3'd1;
	localparam logic [W_IMMSEL-1:0] IMMSEL_U    = 3'd2;
	localparam logic [W_IMMSEL-1:0] IMMSEL_LINK = 3'd3;

	// One instruction word seen as R-type fields or as U/J-type fields
	typedef union packed {
		struct packed {
			logic [6:0]           funct7;
			logic [W_REGADDR-1:0] rs2;
			logic [W_REGADDR-1:0] rs1;
			logic [2:0]           funct3;
			logic [W_REGADDR-1:0] rd;
			logic [6:0]           opcode;
		} r;
		struct packed {
			logic [19:0]          upper;
			logic [W_REGADDR-1:0] rd;
			logic [6:0]           opcode;
		} u;
	} instr_u;

endpackage

// ==== hw/x_ctrl_if.sv ====
/* Decoded execute controls, driven by the opcode decoder and read by the
   immediate generator and the decode top level */
interface x_ctrl_if import rv_decode_pkg::*; ();

	logic [W_REGADDR-1:0] rs1;
	logic [W_REGADDR-1:0] rs2;
	logic [W_REGADDR-1:0] rd;
	logic                 alusrc_a;
	logic                 alusrc_b;
	logic [W_ALUOP-1:0]   aluop;
	logic [W_MEMOP-1:0]   memop;
	logic [W_BCOND-1:0]   branchcond;
	logic [W_EXCEPT-1:0]  except;
	logic [W_IMMSEL-1:0]  imm_sel;

	modport dec (output rs1, rs2, rd, alusrc_a, alusrc_b, aluop, memop, branchcond, except,
		imm_sel);
	modport sink (input rs1, rs2, rd, alusrc_a, alusrc_b, aluop, memop, branchcond, except,
		imm_sel);

endinterface

// ==== hw/pc_cir_ctrl.sv ====
/* Program counter, instruction-register lock and fetch handshake for decode.
   Also flags starvation and speculative instruction bus faults */
module pc_cir_ctrl import rv_decode_pkg::*; #(
	parameter logic [W_ADDR-1:0] RESET_VECTOR = '0
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [1:0]        fd_cir_vld_i,
	input  logic [1:0]        fd_cir_err_i,
	input  logic              x_stall_i,
	input  logic              f_jump_now_i,
	input  logic [W_ADDR-1:0] f_jump_target_i,
	input  logic              x_jump_not_except_i,
	output logic [1:0]        df_cir_use_o,
	output logic              df_cir_lock_o,
	output logic              d_starved_o,
	output logic [W_ADDR-1:0] d_pc_o,
	output logic              bus_fault_o,
	output logic              lock_held_o
);

	logic stall;
	logic lock_req;

	// ------------------------------------------------------------
	// Fetch handshake

	// Every instruction is 32 bits, so both halfwords must be present
	assign d_starved_o = fd_cir_vld_i < 2'd2;
	assign stall = x_stall_i || d_starved_o;
	assign df_cir_use_o = stall ? 2'd0 : 2'd2;

	// Fetch errors are speculative, so only a valid halfword may raise one
	assign bus_fault_o = (fd_cir_vld_i > 2'd0 && fd_cir_err_i[0]) ||
		(fd_cir_vld_i > 2'd1 && fd_cir_err_i[1]);

	// ------------------------------------------------------------
	// Instruction-register lock

	// A jump taken while decode is stalled must keep its instruction in place,
	// otherwise new fetch data could overwrite the link or recovery side effects
	assign lock_req = f_jump_now_i && x_jump_not_except_i && stall;
	assign df_cir_lock_o = lock_req || (lock_held_o && stall);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lock_held_o <= 1'b0;
		end else begin
			lock_held_o <= df_cir_lock_o;
		end
	end

	// ------------------------------------------------------------
	// Program counter

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			d_pc_o <= RESET_VECTOR;
		end else if ((f_jump_now_i && !lock_req) || (lock_held_o && !stall)) begin
			// The target is still presented when a held lock releases
			d_pc_o <= f_jump_target_i;
		end else if (!stall && !df_cir_lock_o) begin
			d_pc_o <= d_pc_o + W_ADDR'(4);
		end
	end

	// Fetch may only be told to advance when a full instruction sits in the register
	assert property (@(posedge clk) disable iff (!rst_n)
		(df_cir_use_o != 2'd0) |-> !d_starved_o)
		else $error("pc_cir_ctrl: halfwords consumed while decode is starved");

	// Reset vector, jump targets and the +4 step all keep word alignment
	assert property (@(posedge clk) disable iff (!rst_n) d_pc_o[1:0] == 2'b00)
		else $error("pc_cir_ctrl: PC %h is not word aligned", d_pc_o);

endmodule

// ==== hw/imm_gen.sv ====
/* Immediate extraction for decode. Builds the I/S/B/U/J forms, picks the
   execute immediate by imm_sel and forms the jump offset */
module imm_gen import rv_decode_pkg::*; (
	input  instr_u            instr_i,
	x_ctrl_if.sink            ctrl,
	output logic [W_DATA-1:0] d_imm_o,
	output logic [W_ADDR-1:0] d_jump_offs_o
);

	logic [6:0]        f7;
	logic [19:0]       upper;
	logic [W_DATA-1:0] imm_i;
	logic [W_DATA-1:0] imm_s;
	logic [W_DATA-1:0] imm_b;
	logic [W_DATA-1:0] imm_u;
	logic [W_DATA-1:0] imm_j;

	// The sign bit is instr[31] in every format
	assign f7 = instr_i.r.funct7;
	assign upper = instr_i.u.upper;

	assign imm_i = {{(W_DATA - 11){f7[6]}}, f7[5:0], instr_i.r.rs2};
	assign imm_s = {{(W_DATA - 11){f7[6]}}, f7[5:0], instr_i.r.rd};
	assign imm_b = {{(W_DATA - 12){f7[6]}}, instr_i.r.rd[0], f7[5:0], instr_i.r.rd[4:1], 1'b0};
	assign imm_u = {upper, {(W_DATA - 20){1'b0}}};
	assign imm_j = {{(W_DATA - 20){upper[19]}}, upper[7:0], upper[8], upper[18:9], 1'b0};

	always_comb begin
		case (ctrl.imm_sel)
			IMMSEL_I:    d_imm_o = imm_i;
			IMMSEL_S:    d_imm_o = imm_s;
			IMMSEL_U:    d_imm_o = imm_u;
			IMMSEL_LINK: d_imm_o = W_DATA'(4);
			default:     d_imm_o = imm_i;
		endcase
	end

	// JAL has opcode bit 3 set, JALR has 3:2 = 01 and branches have 00
	always_comb begin
		casez (instr_i.r.opcode[3:2])
			2'b1?:   d_jump_offs_o = W_ADDR'(imm_j);
			2'b01:   d_jump_offs_o = W_ADDR'(imm_i);
			default: d_jump_offs_o = W_ADDR'(imm_b);
		endcase
	end

endmodule

// ==== hw/instr_ctrl_decode.sv ====
/* Opcode table of the decode stage. Turns the instruction word into execute
   controls, then squashes illegal, starved or faulted instructions */
module instr_ctrl_decode import rv_decode_pkg::*; (
	input  instr_u  instr_i,
	input  logic    starved_i,
	input  logic    bus_fault_i,
	input  logic    lock_held_i,
	x_ctrl_if.dec   ctrl,
	output logic    d_jump_is_regoffs_o
);

	logic [6:0] opc;
	logic [6:0] f7;
	logic [2:0] f3;
	logic       priv_ok;
	logic       illegal;

	function automatic logic [W_ALUOP-1:0] alu_op(input logic [2:0] funct3, input logic alt);
		case (funct3)
			F3_ADD:  alu_op = alt ? ALUOP_SUB : ALUOP_ADD;
			F3_SLL:  alu_op = ALUOP_SLL;
			F3_SLT:  alu_op = ALUOP_LT;
			F3_SLTU: alu_op = ALUOP_LTU;
			F3_XOR:  alu_op = ALUOP_XOR;
			F3_SR:   alu_op = alt ? ALUOP_SRA : ALUOP_SRL;
			F3_OR:   alu_op = ALUOP_OR;
			F3_AND:  alu_op = ALUOP_AND;
		endcase
	endfunction

	assign opc = instr_i.r.opcode;
	assign f7 = instr_i.r.funct7;
	assign f3 = instr_i.r.funct3;

	// ECALL and EBREAK leave every field but rs2 at zero
	assign priv_ok = f7 == F7_BASE && f3 == F3_PRIV && instr_i.r.rs1 == '0 && instr_i.r.rd == '0;

	always_comb begin
		ctrl.rs1 = instr_i.r.rs1;
		ctrl.rs2 = instr_i.r.rs2;
		ctrl.rd = instr_i.r.rd;
		ctrl.imm_sel = IMMSEL_I;
		ctrl.alusrc_a = ALUSRCA_RS1;
		ctrl.alusrc_b = ALUSRCB_RS2;
		ctrl.aluop = ALUOP_ADD;
		ctrl.memop = MEMOP_NONE;
		ctrl.branchcond = BCOND_NEVER;
		ctrl.except = EXCEPT_NONE;
		d_jump_is_regoffs_o = 1'b0;
		illegal = 1'b0;

		case (opc)
			OPC_OP: begin
				ctrl.aluop = alu_op(f3, f7 == F7_ALT);
				// SUB and SRA are the only alternate encodings in the base set
				illegal = !(f7 == F7_BASE || (f7 == F7_ALT && (f3 == F3_ADD || f3 == F3_SR)));
			end
			OPC_OP_IMM: begin
				ctrl.rs2 = '0;
				ctrl.imm_sel = IMMSEL_I;
				ctrl.alusrc_b = ALUSRCB_IMM;
				ctrl.aluop = alu_op(f3, f3 == F3_SR && f7 == F7_ALT);
				if (f3 == F3_SLL)
					illegal = (f7 != F7_BASE);
				else if (f3 == F3_SR)
					illegal = (f7 != F7_BASE && f7 != F7_ALT);
			end
			OPC_LUI, OPC_AUIPC: begin
				ctrl.rs1 = '0;
				ctrl.rs2 = '0;
				ctrl.imm_sel = IMMSEL_U;
				ctrl.alusrc_b = ALUSRCB_IMM;
				if (opc == OPC_AUIPC)
					ctrl.alusrc_a = ALUSRCA_PC;
			end
			OPC_LOAD: begin
				ctrl.rs2 = '0;
				ctrl.alusrc_b = ALUSRCB_IMM;
				case (f3)
					F3_B:    ctrl.memop = MEMOP_LB;
					F3_H:    ctrl.memop = MEMOP_LH;
					F3_W:    ctrl.memop = MEMOP_LW;
					F3_BU:   ctrl.memop = MEMOP_LBU;
					F3_HU:   ctrl.memop = MEMOP_LHU;
					default: illegal = 1'b1;
				endcase
			end
			OPC_STORE: begin
				ctrl.rd = '0;
				ctrl.imm_sel = IMMSEL_S;
				ctrl.alusrc_b = ALUSRCB_IMM;
				case (f3)
					F3_B:    ctrl.memop = MEMOP_SB;
					F3_H:    ctrl.memop = MEMOP_SH;
					F3_W:    ctrl.memop = MEMOP_SW;
					default: illegal = 1'b1;
				endcase
			end
			OPC_BRANCH: begin
				ctrl.rd = '0;
				case (f3)
					F3_BEQ, F3_BNE:   ctrl.aluop = ALUOP_SUB;
					F3_BLT, F3_BGE:   ctrl.aluop = ALUOP_LT;
					F3_BLTU, F3_BGEU: ctrl.aluop = ALUOP_LTU;
					default:          illegal = 1'b1;
				endcase
				// Equal, greater-or-equal and unsigned greater-or-equal all take a zero result
				ctrl.branchcond = (f3 == F3_BEQ || f3 == F3_BGE || f3 == F3_BGEU) ?
					BCOND_ZERO : BCOND_NZERO;
			end
			OPC_JAL, OPC_JALR: begin
				// The ALU computes the link address as PC + 4
				ctrl.rs2 = '0;
				ctrl.imm_sel = IMMSEL_LINK;
				ctrl.alusrc_a = ALUSRCA_PC;
				ctrl.alusrc_b = ALUSRCB_IMM;
				ctrl.branchcond = BCOND_ALWAYS;
				if (opc == OPC_JAL) begin
					ctrl.rs1 = '0;
				end else begin
					d_jump_is_regoffs_o = 1'b1;
					illegal = (f3 != F3_JALR);
				end
			end
			OPC_MISC_MEM: begin
				// FENCE has nothing to order in this core and retires as a no-op
				ctrl.rd = '0;
				illegal = (f3 != F3_FENCE);
			end
			OPC_SYSTEM: begin
				ctrl.rs1 = '0;
				ctrl.rs2 = '0;
				ctrl.rd = '0;
				if (priv_ok && instr_i.r.rs2 == PRIV_ECALL)
					ctrl.except = EXCEPT_ECALL;
				else if (priv_ok && instr_i.r.rs2 == PRIV_EBREAK)
					ctrl.except = EXCEPT_EBREAK;
				else
					illegal = 1'b1;
			end
			default: illegal = 1'b1;
		endcase

		// ------------------------------------------------------------
		// Squash: no register, memory or branch side effects

		if (illegal || starved_i || bus_fault_i) begin
			ctrl.rs1 = '0;
			ctrl.rs2 = '0;
			ctrl.rd = '0;
			ctrl.memop = MEMOP_NONE;
			ctrl.branchcond = BCOND_NEVER;
			ctrl.except = EXCEPT_NONE;
			// A starved word is partial, so it cannot be judged illegal yet
			if (bus_fault_i)
				ctrl.except = EXCEPT_INSTR_FAULT;
			else if (illegal && !starved_i)
				ctrl.except = EXCEPT_INSTR_ILLEGAL;
		end

		// The locked jump has already been taken once
		if (lock_held_i)
			ctrl.branchcond = BCOND_NEVER;

		// An excepting instruction must never reach the bus
		assert (ctrl.except == EXCEPT_NONE || ctrl.memop == MEMOP_NONE)
			else $error("instr_ctrl_decode: memop %0d with exception %0d", ctrl.memop,
				ctrl.except);
	end

endmodule

// ==== hw/rv_decode.sv ====
/* Decode stage top level. Connects the PC/lock control, the opcode decoder
   and the immediate generator to the fetch and execute ports */
module rv_decode import rv_decode_pkg::*; #(
	parameter logic [W_ADDR-1:0] RESET_VECTOR = 32'h0000_0000
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [31:0]          fd_cir_i,
	input  logic [1:0]           fd_cir_err_i,
	input  logic [1:0]           fd_cir_vld_i,
	input  logic                 x_stall_i,
	input  logic                 f_jump_now_i,
	input  logic [W_ADDR-1:0]    f_jump_target_i,
	input  logic                 x_jump_not_except_i,
	output logic [1:0]           df_cir_use_o,
	output logic                 df_cir_lock_o,
	output logic [W_ADDR-1:0]    d_pc_o,
	output logic                 d_starved_o,
	output logic [W_DATA-1:0]    d_imm_o,
	output logic [W_REGADDR-1:0] d_rs1_o,
	output logic [W_REGADDR-1:0] d_rs2_o,
	output logic [W_REGADDR-1:0] d_rd_o,
	output logic                 d_alusrc_a_o,
	output logic                 d_alusrc_b_o,
	output logic [W_ALUOP-1:0]   d_aluop_o,
	output logic [W_MEMOP-1:0]   d_memop_o,
	output logic [W_BCOND-1:0]   d_branchcond_o,
	output logic [W_ADDR-1:0]    d_jump_offs_o,
	output logic                 d_jump_is_regoffs_o,
	output logic [W_EXCEPT-1:0]  d_except_o
);

	instr_u cir;
	logic   bus_fault;
	logic   lock_held;

	x_ctrl_if ctrl ();

	assign cir = fd_cir_i;

	pc_cir_ctrl #(
		.RESET_VECTOR(RESET_VECTOR)
	) u_pc_cir_ctrl (
		.clk                (clk),
		.rst_n              (rst_n),
		.fd_cir_vld_i       (fd_cir_vld_i),
		.fd_cir_err_i       (fd_cir_err_i),
		.x_stall_i          (x_stall_i),
		.f_jump_now_i       (f_jump_now_i),
		.f_jump_target_i    (f_jump_target_i),
		.x_jump_not_except_i(x_jump_not_except_i),
		.df_cir_use_o       (df_cir_use_o),
		.df_cir_lock_o      (df_cir_lock_o),
		.d_starved_o        (d_starved_o),
		.d_pc_o             (d_pc_o),
		.bus_fault_o        (bus_fault),
		.lock_held_o        (lock_held)
	);

	instr_ctrl_decode u_instr_ctrl_decode (
		.instr_i            (cir),
		.starved_i          (d_starved_o),
		.bus_fault_i        (bus_fault),
		.lock_held_i        (lock_held),
		.ctrl               (ctrl),
		.d_jump_is_regoffs_o(d_jump_is_regoffs_o)
	);

	imm_gen u_imm_gen (
		.instr_i      (cir),
		.ctrl         (ctrl),
		.d_imm_o      (d_imm_o),
		.d_jump_offs_o(d_jump_offs_o)
	);

	// Execute controls leave through plain ports
	assign d_rs1_o = ctrl.rs1;
	assign d_rs2_o = ctrl.rs2;
	assign d_rd_o = ctrl.rd;
	assign d_alusrc_a_o = ctrl.alusrc_a;
	assign d_alusrc_b_o = ctrl.alusrc_b;
	assign d_aluop_o = ctrl.aluop;
	assign d_memop_o = ctrl.memop;
	assign d_branchcond_o = ctrl.branchcond;
	assign d_except_o = ctrl.except;

endmodule

// ==== tests/tb_rv_decode.sv ====
/* Self-checking testbench for the decode stage. Drives random and directed instruction
   words, stalls and jumps, and checks every output against rules kept in the testbench */
module tb_rv_decode import rv_decode_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam logic [W_ADDR-1:0] RESET_VECTOR = 32'h0000_0100;
	localparam logic [31:0] SEED = 32'hc3f0_f475;
	localparam int N_RAND = 200;
	localparam int N_TESTS = N_RAND + 50;
	localparam int WATCHDOG_CYCLES = N_TESTS * 20;

	localparam logic [2:0] LOAD_F3 [5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
	localparam logic [W_MEMOP-1:0] LOAD_OPS [5] =
		'{MEMOP_LB, MEMOP_LH, MEMOP_LW, MEMOP_LBU, MEMOP_LHU};
	localparam logic [W_MEMOP-1:0] STORE_OPS [3] = '{MEMOP_SB, MEMOP_SH, MEMOP_SW};
	localparam logic [2:0] BRANCH_F3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
	// MUL, CSRRW, MRET, WFI, FENCE.I and SLLI with a nonzero funct7
	localparam logic [31:0] ILLEGAL_WORDS [6] = '{32'h02b5_0533, 32'h3052_9073,
		32'h3020_0073, 32'h1050_0073, 32'h0000_100f, 32'h4000_1013};

	logic                 clk;
	logic                 rst_n;
	logic [31:0]          fd_cir_i;
	logic [1:0]           fd_cir_err_i;
	logic [1:0]           fd_cir_vld_i;
	logic                 x_stall_i;
	logic                 f_jump_now_i;
	logic [W_ADDR-1:0]    f_jump_target_i;
	logic                 x_jump_not_except_i;
	logic [1:0]           df_cir_use_o;
	logic                 df_cir_lock_o;
	logic [W_ADDR-1:0]    d_pc_o;
	logic                 d_starved_o;
	logic [W_DATA-1:0]    d_imm_o;
	logic [W_REGADDR-1:0] d_rs1_o;
	logic [W_REGADDR-1:0] d_rs2_o;
	logic [W_REGADDR-1:0] d_rd_o;
	logic                 d_alusrc_a_o;
	logic                 d_alusrc_b_o;
	logic [W_ALUOP-1:0]   d_aluop_o;
	logic [W_MEMOP-1:0]   d_memop_o;
	logic [W_BCOND-1:0]   d_branchcond_o;
	logic [W_ADDR-1:0]    d_jump_offs_o;
	logic                 d_jump_is_regoffs_o;
	logic [W_EXCEPT-1:0]  d_except_o;

	// Expected state and outputs for the cycle being applied
	logic [31:0]          rng;
	logic [W_ADDR-1:0]    exp_pc;
	logic                 exp_held;
	logic [W_REGADDR-1:0] exp_rs1;
	logic [W_REGADDR-1:0] exp_rs2;
	logic [W_REGADDR-1:0] exp_rd;
	logic                 exp_a;
	logic                 exp_b;
	logic [W_ALUOP-1:0]   exp_alu;
	logic [W_MEMOP-1:0]   exp_mem;
	logic [W_BCOND-1:0]   exp_bc;
	logic [W_EXCEPT-1:0]  exp_exc;
	logic [W_DATA-1:0]    exp_imm;
	logic [W_ADDR-1:0]    exp_offs;
	logic                 exp_regoffs;
	logic                 full_check;
	logic                 offs_check;

	rv_decode #(
		.RESET_VECTOR(RESET_VECTOR)
	) i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the test sequence completed");
		abort_run();
	end

	// ------------------------------------------------------------
	// Helpers

	task automatic abort_run();
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			$display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Sign-extended immediates laid out as in the ISA manual
	function automatic logic [31:0] imm_of(input logic [31:0] w, input logic [7:0] fmt);
		case (fmt)
			"S":     return {{20{w[31]}}, w[31:25], w[11:7]};
			"B":     return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			"U":     return {w[31:12], 12'h000};
			"J":     return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default: return {{20{w[31]}}, w[31:20]};
		endcase
	endfunction

	function automatic logic [W_ALUOP-1:0] aluop_for(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALUOP_SUB : ALUOP_ADD;
			3'b001:  return ALUOP_SLL;
			3'b010:  return ALUOP_LT;
			3'b011:  return ALUOP_LTU;
			3'b100:  return ALUOP_XOR;
			3'b101:  return alt ? ALUOP_SRA : ALUOP_SRL;
			3'b110:  return ALUOP_OR;
			default: return ALUOP_AND;
		endcase
	endfunction

	// Kinds 0..8 are OP, OP-IMM, LUI, AUIPC, load, store, branch, JAL and JALR
	task automatic build_legal_word(input int kind, input logic [31:0] r,
		output logic [31:0] w);
		logic [2:0] f3;
		logic       alt;
		logic [7:0] fmt;
		logic [7:0] ofmt;
		int         idx;
		f3 = r[14:12];
		alt = r[30];
		fmt = "I";
		ofmt = "B";
		exp_rs1 = r[19:15];
		exp_rs2 = r[24:20];
		exp_rd = r[11:7];
		exp_a = ALUSRCA_RS1;
		exp_b = ALUSRCB_RS2;
		exp_alu = ALUOP_ADD;
		exp_mem = MEMOP_NONE;
		exp_bc = BCOND_NEVER;
		exp_exc = EXCEPT_NONE;
		exp_regoffs = 1'b0;
		offs_check = 1'b0;
		w = {r[31:7], OPC_OP};
		case (kind)
			0: begin
				alt = alt && (f3 == 3'b000 || f3 == 3'b101);
				w = {1'b0, alt, 5'b00000, r[24:7], OPC_OP};
				exp_alu = aluop_for(f3, alt);
			end
			1: begin
				if (f3 == 3'b001)
					w = {7'b0000000, r[24:7], OPC_OP_IMM};
				else if (f3 == 3'b101)
					w = {1'b0, alt, 5'b00000, r[24:7], OPC_OP_IMM};
				else
					w = {r[31:7], OPC_OP_IMM};
				exp_rs2 = '0;
				exp_b = ALUSRCB_IMM;
				exp_alu = aluop_for(f3, f3 == 3'b101 && alt);
			end
			2, 3: begin
				w = {r[31:7], (kind == 2) ? OPC_LUI : OPC_AUIPC};
				exp_rs1 = '0;
				exp_rs2 = '0;
				exp_a = (kind == 3) ? ALUSRCA_PC : ALUSRCA_RS1;
				exp_b = ALUSRCB_IMM;
				fmt = "U";
			end
			4: begin
				idx = int'(r % 5);
				w = {r[31:15], LOAD_F3[idx], r[11:7], OPC_LOAD};
				exp_rs2 = '0;
				exp_b = ALUSRCB_IMM;
				exp_mem = LOAD_OPS[idx];
			end
			5: begin
				idx = int'(r % 3);
				w = {r[31:15], LOAD_F3[idx], r[11:7], OPC_STORE};
				exp_rd = '0;
				exp_b = ALUSRCB_IMM;
				exp_mem = STORE_OPS[idx];
				fmt = "S";
			end
			6: begin
				f3 = BRANCH_F3[int'(r % 6)];
				w = {r[31:15], f3, r[11:7], OPC_BRANCH};
				exp_rd = '0;
				exp_alu = (f3[2:1] == 2'b00) ? ALUOP_SUB : (f3[1] ? ALUOP_LTU : ALUOP_LT);
				// BEQ, BGE and BGEU are taken on a zero ALU result
				exp_bc = (f3 == 3'b000 || f3 == 3'b101 || f3 == 3'b111) ?
					BCOND_ZERO : BCOND_NZERO;
				offs_check = 1'b1;
			end
			default: begin
				if (kind == 7) begin
					w = {r[31:7], OPC_JAL};
					exp_rs1 = '0;
					ofmt = "J";
				end else begin
					w = {r[31:15], 3'b000, r[11:7], OPC_JALR};
					exp_regoffs = 1'b1;
					ofmt = "I";
				end
				exp_rs2 = '0;
				exp_a = ALUSRCA_PC;
				exp_b = ALUSRCB_IMM;
				exp_bc = BCOND_ALWAYS;
				fmt = "L";
				offs_check = 1'b1;
			end
		endcase
		if (fmt == "L")
			exp_imm = 32'd4;
		else
			exp_imm = imm_of(w, fmt);
		exp_offs = imm_of(w, ofmt);
		full_check = 1'b1;
	endtask

	task automatic expect_squashed(input logic [W_EXCEPT-1:0] exc);
		exp_rs1 = '0;
		exp_rs2 = '0;
		exp_rd = '0;
		exp_mem = MEMOP_NONE;
		exp_bc = BCOND_NEVER;
		exp_exc = exc;
		full_check = 1'b0;
		offs_check = 1'b0;
	endtask

	// Drives one cycle on the falling edge, checks in the low phase, then advances
	// the expected PC and lock state by the PC and lock rules
	task automatic apply_cycle(input logic [31:0] w, input logic [1:0] vld,
		input logic [1:0] err, input logic stall, input logic jump, input logic jne,
		input logic [W_ADDR-1:0] target);
		logic stalled;
		logic lock_req;
		logic lock;
		@(negedge clk);
		fd_cir_i = w;
		fd_cir_vld_i = vld;
		fd_cir_err_i = err;
		x_stall_i = stall;
		f_jump_now_i = jump;
		x_jump_not_except_i = jne;
		f_jump_target_i = target;
		#(CLK_PERIOD / 4);
		stalled = stall || vld < 2'd2;
		lock_req = jump && jne && stalled;
		lock = lock_req || (exp_held && stalled);
		if (exp_held)
			exp_bc = BCOND_NEVER;
		check_value("d_pc_o", exp_pc, d_pc_o);
		check_value("d_starved_o", 32'(vld < 2'd2), 32'(d_starved_o));
		check_value("df_cir_use_o", stalled ? 32'd0 : 32'd2, 32'(df_cir_use_o));
		check_value("df_cir_lock_o", 32'(lock), 32'(df_cir_lock_o));
		check_value("d_rs1_o", 32'(exp_rs1), 32'(d_rs1_o));
		check_value("d_rs2_o", 32'(exp_rs2), 32'(d_rs2_o));
		check_value("d_rd_o", 32'(exp_rd), 32'(d_rd_o));
		check_value("d_memop_o", 32'(exp_mem), 32'(d_memop_o));
		check_value("d_branchcond_o", 32'(exp_bc), 32'(d_branchcond_o));
		check_value("d_except_o", 32'(exp_exc), 32'(d_except_o));
		if (full_check) begin
			check_value("d_alusrc_a_o", 32'(exp_a), 32'(d_alusrc_a_o));
			check_value("d_alusrc_b_o", 32'(exp_b), 32'(d_alusrc_b_o));
			check_value("d_aluop_o", 32'(exp_alu), 32'(d_aluop_o));
			check_value("d_imm_o", exp_imm, d_imm_o);
			check_value("d_jump_is_regoffs_o", 32'(exp_regoffs), 32'(d_jump_is_regoffs_o));
		end
		if (offs_check)
			check_value("d_jump_offs_o", exp_offs, d_jump_offs_o);
		if ((jump && !lock_req) || (exp_held && !stalled))
			exp_pc = target;
		else if (!stalled && !lock)
			exp_pc = exp_pc + 32'd4;
		exp_held = lock;
	endtask

	// Fetch must never be told to advance under back-pressure or with a partial word
	assert property (@(posedge clk) disable iff (!rst_n)
		(x_stall_i || fd_cir_vld_i < 2'd2) |-> df_cir_use_o == 2'd0)
		else begin
			$display("ERROR %0t df_cir_use_o expected 0 actual %0d", $time, df_cir_use_o);
			abort_run();
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		d_starved_o == (fd_cir_vld_i < 2'd2))
		else begin
			$display("ERROR %0t d_starved_o expected %0d actual %0d", $time,
				fd_cir_vld_i < 2'd2, d_starved_o);
			abort_run();
		end

	// ------------------------------------------------------------
	// Test sequence

	initial begin
		logic [31:0] w;
		int          kind;
		logic        stall;
		rng = SEED;
		exp_pc = RESET_VECTOR;
		exp_held = 1'b0;
		rst_n = 1'b0;
		fd_cir_i = '0;
		fd_cir_vld_i = 2'd0;
		fd_cir_err_i = 2'b00;
		x_stall_i = 1'b0;
		f_jump_now_i = 1'b0;
		f_jump_target_i = '0;
		x_jump_not_except_i = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Out of reset fetch is empty, so nothing may be judged illegal yet
		expect_squashed(EXCEPT_NONE);
		apply_cycle(32'h0, 2'd0, 2'b00, 1'b0, 1'b0, 1'b0, '0);

		// Decode table and jumps, with occasional back-pressure
		for (int i = 0; i < N_RAND; i++) begin
			rng = xorshift(rng);
			kind = int'(rng % 9);
			stall = rng[31:30] == 2'b11;
			rng = xorshift(rng);
			build_legal_word(kind, rng, w);
			apply_cycle(w, 2'd2, 2'b00, stall, 1'b0, 1'b0, '0);
		end

		// Opcodes outside the 32-bit space, then dropped extensions and system ops
		for (int i = 0; i < 16; i++) begin
			rng = xorshift(rng);
			expect_squashed(EXCEPT_INSTR_ILLEGAL);
			apply_cycle({rng[31:2], ((rng[1:0] == 2'b11) ? 2'b10 : rng[1:0])}, 2'd2, 2'b00,
				1'b0, 1'b0, 1'b0, '0);
		end
		foreach (ILLEGAL_WORDS[i]) begin
			expect_squashed(EXCEPT_INSTR_ILLEGAL);
			apply_cycle(ILLEGAL_WORDS[i], 2'd2, 2'b00, 1'b0, 1'b0, 1'b0, '0);
		end

		// Starved store: an error on the missing half is not a fault
		expect_squashed(EXCEPT_NONE);
		apply_cycle(32'h00b5_2023, 2'd0, 2'b00, 1'b0, 1'b0, 1'b0, '0);
		apply_cycle(32'h00b5_2023, 2'd1, 2'b10, 1'b0, 1'b0, 1'b0, '0);
		expect_squashed(EXCEPT_INSTR_FAULT);
		apply_cycle(32'h00b5_2023, 2'd2, 2'b01, 1'b0, 1'b0, 1'b0, '0);
		apply_cycle(32'h00b5_2023, 2'd2, 2'b10, 1'b0, 1'b0, 1'b0, '0);
		apply_cycle(32'h00b5_2023, 2'd1, 2'b01, 1'b0, 1'b0, 1'b0, '0);
		expect_squashed(EXCEPT_ECALL);
		apply_cycle(32'h0000_0073, 2'd2, 2'b00, 1'b0, 1'b0, 1'b0, '0);
		expect_squashed(EXCEPT_EBREAK);
		apply_cycle(32'h0010_0073, 2'd2, 2'b00, 1'b0, 1'b0, 1'b0, '0);

		// Back-pressure holds the PC, then stepping resumes
		build_legal_word(0, 32'h0, w);
		repeat (3) apply_cycle(w, 2'd2, 2'b00, 1'b1, 1'b0, 1'b0, '0);
		repeat (3) apply_cycle(w, 2'd2, 2'b00, 1'b0, 1'b0, 1'b0, '0);

		// A branch word keeps the forced condition visible while the lock is held
		rng = xorshift(rng);
		build_legal_word(6, rng, w);
		apply_cycle(w, 2'd2, 2'b00, 1'b0, 1'b1, 1'b1, 32'h0000_2000);
		build_legal_word(6, rng, w);
		apply_cycle(w, 2'd2, 2'b00, 1'b1, 1'b1, 1'b1, 32'h0000_3000);
		build_legal_word(6, rng, w);
		apply_cycle(w, 2'd2, 2'b00, 1'b1, 1'b0, 1'b0, 32'h0000_3000);
		build_legal_word(6, rng, w);
		apply_cycle(w, 2'd2, 2'b00, 1'b0, 1'b0, 1'b0, 32'h0000_3000);
		build_legal_word(6, rng, w);
		apply_cycle(w, 2'd2, 2'b00, 1'b0, 1'b0, 1'b0, '0);

		// Starvation stalls a jump just like back-pressure
		expect_squashed(EXCEPT_NONE);
		apply_cycle(w, 2'd1, 2'b00, 1'b0, 1'b1, 1'b1, 32'h0000_4000);
		build_legal_word(6, rng, w);
		apply_cycle(w, 2'd2, 2'b00, 1'b0, 1'b0, 1'b0, 32'h0000_4000);

		// Without execute's confirmation a stalled jump goes straight through
		build_legal_word(6, rng, w);
		apply_cycle(w, 2'd2, 2'b00, 1'b1, 1'b1, 1'b0, 32'h0000_5000);
		build_legal_word(6, rng, w);
		apply_cycle(w, 2'd2, 2'b00, 1'b0, 1'b0, 1'b0, '0);

		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+include
hw/rv_decode_pkg.sv
hw/x_ctrl_if.sv
hw/pc_cir_ctrl.sv
hw/imm_gen.sv
hw/instr_ctrl_decode.sv
hw/rv_decode.sv
tests/tb_rv_decode.sv

// ==== Makefile ====
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_decode
SEED      ?= 1
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run $(TOP) from $(FILELIST)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP SEED FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(BUILD_DIR)
